//--- hw/rename_pkg.sv
`default_nettype none

package rename_pkg;

    // Retire bandwidth of the core.
    localparam int retire_width = 2;

    // Architectural register file. Register 0 reads as zero and is never renamed.
    localparam int arch_reg_count = 32;

    // Physical register file shared by both rename tables.
    localparam int phys_reg_count = 64;

    // Every physical register that the RRAT does not name sits in the free list.
    localparam int free_list_depth = phys_reg_count - arch_reg_count;

    localparam int arn_width = $clog2(arch_reg_count);
    localparam int prn_width = $clog2(phys_reg_count);

    // One extra bit so that a full list can be counted.
    localparam int free_count_width = $clog2(free_list_depth + 1);

    typedef logic [arn_width-1:0] arn_t;

    typedef logic [prn_width-1:0] prn_t;

    typedef logic [free_count_width-1:0] free_count_t;

endpackage

`default_nettype wire

//--- hw/rrat_free_list.sv
`timescale 1ns/1ns
`default_nettype none

module rrat_free_list
    import rename_pkg::*;
(
    input  logic                    clock,
    input  logic                    reset,
    input  logic [retire_width-1:0] pop_en,
    input  logic [retire_width-1:0] push_valid,
    input  prn_t [retire_width-1:0] push_prn,
    output logic [retire_width-1:0] pop_valid,
    output prn_t [retire_width-1:0] pop_prn,
    output free_count_t             free_count
);

    // The depth is a power of two, so head and tail wrap on their own.
    typedef logic [$clog2(free_list_depth)-1:0] ptr_t;

    prn_t [free_list_depth-1:0] ring;
    ptr_t                       head;
    ptr_t                       tail;
    free_count_t                count;

    // Running totals over the slots of the current cycle.
    free_count_t pop_total;
    free_count_t pop_taken;
    free_count_t push_total;

    ptr_t [retire_width-1:0] push_slot;

    // Pop answer i sits past every lower slot that asked for a register.
    always_comb begin
        pop_total = '0;
        pop_taken = '0;
        for (int i = 0; i < retire_width; i++) begin
            pop_valid[i] = pop_total < count;
            pop_prn[i]   = ring[ptr_t'(head + pop_total)];
            if (pop_en[i]) begin
                pop_total = pop_total + 1'b1;
                if (pop_valid[i]) begin
                    pop_taken = pop_taken + 1'b1;
                end
            end
        end
    end

    // Freed registers go in at the tail in slot order.
    always_comb begin
        push_total = '0;
        for (int i = 0; i < retire_width; i++) begin
            push_slot[i] = ptr_t'(tail + push_total);
            if (push_valid[i]) begin
                push_total = push_total + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= free_count_t'(free_list_depth);
            for (int i = 0; i < free_list_depth; i++) begin
                ring[i] <= prn_t'(arch_reg_count + i);
            end
        end else begin
            head  <= ptr_t'(head + pop_taken);
            tail  <= ptr_t'(tail + push_total);
            count <= count - pop_taken + push_total;
            for (int i = 0; i < retire_width; i++) begin
                if (push_valid[i]) begin
                    ring[push_slot[i]] <= push_prn[i];
                end
            end
        end
    end

    assign free_count = count;

    // The RRAT never asks for a register the list cannot give.
    pop_when_empty: assert property (
        @(posedge clock) disable iff (reset)
        (pop_en & ~pop_valid) == '0
    ) else $error("Free list popped with no register available.");

    // Pushes only return registers that were popped earlier.
    count_in_range: assert property (
        @(posedge clock) disable iff (reset)
        count <= free_count_t'(free_list_depth)
    ) else $error("Free list count above its depth.");

endmodule

`default_nettype wire

//--- hw/rrat.sv
`timescale 1ns/1ns
`default_nettype none

module rrat
    import rename_pkg::*;
(
    input  logic                      clock,
    input  logic                      reset,
    input  arn_t [retire_width-1:0]   arns,
    input  logic [retire_width-1:0]   success,
    output logic [retire_width-1:0]   free_valid,
    output prn_t [retire_width-1:0]   free_prn,
    output logic                      squash,
    output prn_t [arch_reg_count-1:0] entries,
    output free_count_t               free_count
);

    prn_t [arch_reg_count-1:0] rrat_table;
    prn_t [arch_reg_count-1:0] next_rrat_table;
    logic                      success_q;

    // running[i] is high when every slot below i succeeded.
    logic [retire_width:0] running;

    logic [retire_width-1:0] pop_en;
    logic [retire_width-1:0] pop_valid;
    prn_t [retire_width-1:0] pop_prn;

    rrat_free_list free_list (
        .clock      (clock),
        .reset      (reset),
        .pop_en     (pop_en),
        .push_valid (free_valid),
        .push_prn   (free_prn),
        .pop_valid  (pop_valid),
        .pop_prn    (pop_prn),
        .free_count (free_count)
    );

    // The failing slot still retires; only the slots after it are dropped.
    always_comb begin
        running[0] = 1'b1;
        for (int i = 0; i < retire_width; i++) begin
            pop_en[i]      = running[i] && (arns[i] != '0);
            running[i + 1] = running[i] && success[i];
        end
    end

    // Walk the slots on a working copy so that a later slot to the same
    // register frees what an earlier slot just wrote.
    always_comb begin
        next_rrat_table = rrat_table;
        for (int i = 0; i < retire_width; i++) begin
            free_valid[i] = pop_en[i];
            free_prn[i]   = '0;
            if (pop_en[i]) begin
                free_prn[i] = next_rrat_table[arns[i]];
                if (pop_valid[i]) begin
                    next_rrat_table[arns[i]] = pop_prn[i];
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            success_q <= 1'b1;
            for (int i = 0; i < arch_reg_count; i++) begin
                rrat_table[i] <= prn_t'(i);
            end
        end else begin
            success_q  <= running[retire_width];
            rrat_table <= next_rrat_table;
        end
    end

    assign squash  = ~success_q;
    assign entries = rrat_table;

    zero_reg_fixed: assert property (
        @(posedge clock) disable iff (reset)
        entries[0] == '0
    ) else $error("Architectural register 0 was remapped.");

    no_squash_after_reset: assert property (
        @(posedge clock)
        reset |=> !squash
    ) else $error("Squash high on the cycle after reset.");

endmodule

`default_nettype wire

//--- hw/retire_rename.sv
`timescale 1ns/1ns
`default_nettype none

// Boundary seen by the retire stage of the core.
module retire_rename
    import rename_pkg::*;
(
    input  logic                      clock,
    input  logic                      reset,
    input  arn_t [retire_width-1:0]   arns,
    input  logic [retire_width-1:0]   success,
    output logic [retire_width-1:0]   free_valid,
    output prn_t [retire_width-1:0]   free_prn,
    output logic                      squash,
    output prn_t [arch_reg_count-1:0] entries,
    output free_count_t               free_count
);

    // Retire slots go straight into the committed table.
    rrat rrat_inst (
        .clock      (clock),
        .reset      (reset),
        .arns       (arns),
        .success    (success),
        .free_valid (free_valid),
        .free_prn   (free_prn),
        .squash     (squash),
        .entries    (entries),
        .free_count (free_count)
    );

endmodule

`default_nettype wire

//--- include/rrat_checks.svh
`ifndef RRAT_CHECKS_SVH
`define RRAT_CHECKS_SVH

// Each task bumps errors and prints one line when the values differ.

task automatic check_prn(input string name, input rename_pkg::prn_t expected,
                         input rename_pkg::prn_t actual, inout int errors);
    if (actual !== expected) begin
        $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
        errors++;
    end
endtask

task automatic check_slots(input string name,
                           input logic [rename_pkg::retire_width-1:0] expected,
                           input logic [rename_pkg::retire_width-1:0] actual,
                           inout int errors);
    if (actual !== expected) begin
        $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
        errors++;
    end
endtask

task automatic check_bit(input string name, input logic expected, input logic actual,
                         inout int errors);
    if (actual !== expected) begin
        $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
        errors++;
    end
endtask

task automatic check_count(input string name, input rename_pkg::free_count_t expected,
                           input rename_pkg::free_count_t actual, inout int errors);
    if (actual !== expected) begin
        $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
        errors++;
    end
endtask

`endif

//--- bench/rrat_tb.sv
`timescale 1ns/1ns
`default_nettype none

module rrat_tb
    import rename_pkg::*;
();

    logic                      clock;
    logic                      reset;
    arn_t [retire_width-1:0]   arns;
    logic [retire_width-1:0]   success;
    logic [retire_width-1:0]   free_valid;
    prn_t [retire_width-1:0]   free_prn;
    logic                      squash;
    prn_t [arch_reg_count-1:0] entries;
    free_count_t               free_count;

    int mismatches = 0;
    int other_errors = 0;
    int line_count = 0;
    bit loaded = 1'b0;

    // One entry per golden line, in file order.
    int gold_arn0[$];
    int gold_arn1[$];
    int gold_succ[$];
    int gold_fv[$];
    int gold_fp0[$];
    int gold_fp1[$];
    int gold_sq[$];
    int gold_carn[$];
    int gold_cprn[$];

    `include "rrat_checks.svh"

    retire_rename dut (
        .clock      (clock),
        .reset      (reset),
        .arns       (arns),
        .success    (success),
        .free_valid (free_valid),
        .free_prn   (free_prn),
        .squash     (squash),
        .entries    (entries),
        .free_count (free_count)
    );

    always #5 clock = ~clock;

    function automatic bit is_blank_or_comment(input string text);
        for (int i = 0; i < text.len(); i++) begin
            if (text[i] == "#") begin
                return 1'b1;
            end
            if (text[i] != " " && text[i] != "\t" && text[i] != "\n" && text[i] != "\r") begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic load_golden();
        int    fd;
        int    line_no;
        int    fields;
        string text;
        int    v[9];
        fd = $fopen("bench/rrat_golden.txt", "r");
        line_no = 0;
        if (fd == 0) begin
            $display("Could not open the golden file bench/rrat_golden.txt.");
            other_errors++;
            return;
        end
        while ($fgets(text, fd) != 0) begin
            line_no++;
            if (!is_blank_or_comment(text)) begin
                fields = $sscanf(text, "%h %h %h %h %h %h %h %h %h",
                                 v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8]);
                if (fields != 9) begin
                    $display("Golden file line %0d could not be read.", line_no);
                    other_errors++;
                end else begin
                    gold_arn0.push_back(v[0]);
                    gold_arn1.push_back(v[1]);
                    gold_succ.push_back(v[2]);
                    gold_fv.push_back(v[3]);
                    gold_fp0.push_back(v[4]);
                    gold_fp1.push_back(v[5]);
                    gold_sq.push_back(v[6]);
                    gold_carn.push_back(v[7]);
                    gold_cprn.push_back(v[8]);
                end
            end
        end
        $fclose(fd);
        line_count = gold_arn0.size();
        if (line_count == 0) begin
            $display("The golden file holds no stimulus lines.");
            other_errors++;
        end
    endtask

    task automatic check_reset_state();
        for (int i = 0; i < arch_reg_count; i++) begin
            check_prn($sformatf("entries[%0d]", i), prn_t'(i), entries[i], mismatches);
        end
        check_bit("squash", 1'b0, squash, mismatches);
        check_count("free_count", free_count_t'(free_list_depth), free_count, mismatches);
        check_slots("free_valid", '0, free_valid, mismatches);
    endtask

    task automatic apply_inputs(input int k);
        arns[0] = arn_t'(gold_arn0[k]);
        arns[1] = arn_t'(gold_arn1[k]);
        success = retire_width'(gold_succ[k]);
    endtask

    // Results that follow the inputs within the same cycle.
    task automatic check_retire_outputs(input int k);
        logic [retire_width-1:0] exp_fv;
        exp_fv = retire_width'(gold_fv[k]);
        check_slots("free_valid", exp_fv, free_valid, mismatches);
        if (exp_fv[0]) begin
            check_prn("free_prn[0]", prn_t'(gold_fp0[k]), free_prn[0], mismatches);
        end
        if (exp_fv[1]) begin
            check_prn("free_prn[1]", prn_t'(gold_fp1[k]), free_prn[1], mismatches);
        end
        // Every processed slot pushes one register and pops one.
        check_count("free_count", free_count_t'(free_list_depth), free_count, mismatches);
    endtask

    // Results registered at the edge that closes the cycle of line k.
    task automatic check_committed_state(input int k);
        check_bit("squash", gold_sq[k] != 0, squash, mismatches);
        check_prn($sformatf("entries[%0d]", gold_carn[k]), prn_t'(gold_cprn[k]),
                  entries[gold_carn[k]], mismatches);
    endtask

    initial begin
        clock = 1'b0;
        reset = 1'b1;
        arns = '0;
        success = '1;
        load_golden();
        loaded = 1'b1;
        repeat (4) @(posedge clock);
        #1;
        reset = 1'b0;
        #8;
        check_reset_state();
        for (int k = 0; k < line_count; k++) begin
            @(posedge clock);
            #1;
            apply_inputs(k);
            #8;
            check_retire_outputs(k);
            if (k > 0) begin
                check_committed_state(k - 1);
            end
        end
        @(posedge clock);
        #1;
        arns = '0;
        success = '1;
        #8;
        if (line_count > 0) begin
            check_committed_state(line_count - 1);
        end
        $display("Mismatches: %0d, other errors: %0d", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // The limit allows ten periods per golden line on top of a fixed margin.
    initial begin
        wait (loaded);
        #((20 + 10 * line_count) * 10);
        $display("Timeout: the run did not finish within %0d clock periods.",
                 20 + 10 * line_count);
        $display("Mismatches: %0d, other errors: %0d", mismatches, other_errors);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+include
hw/rename_pkg.sv
hw/rrat_free_list.sv
hw/rrat.sv
hw/retire_rename.sv
bench/rrat_tb.sv

//--- Bender.yml
package:
  name: retire_rename

sources:
  - include_dirs:
      - include
    files:
      - hw/rename_pkg.sv
      - hw/rrat_free_list.sv
      - hw/rrat.sv
      - hw/retire_rename.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - bench/rrat_tb.sv

//--- bench/rrat_golden.txt
# arn0 arn1 success | free_valid free_prn0 free_prn1 | squash_next check_arn check_prn
# Success and free_valid hold slot 0 in bit 0. The last three columns are seen one cycle later.
# A free_prn column is only compared when its free_valid bit is set.
00 00 3 0 00 00 0 05 05
05 00 3 1 05 00 0 05 20
00 07 3 2 00 07 0 07 21
03 0a 3 3 03 0a 0 03 22
00 00 3 0 00 00 0 0a 23
05 05 3 3 20 24 0 05 25
0b 0c 2 1 0b 00 1 0b 26
00 00 3 0 00 00 0 0c 0c
0c 0d 1 3 0c 0d 1 0d 28
00 0e 2 0 00 00 1 0e 0e
00 00 3 0 00 00 0 0c 27
01 02 3 3 01 02 0 01 29
03 04 3 3 22 04 0 04 2c
06 08 3 3 06 08 0 08 2e
09 0f 3 3 09 0f 0 0f 30
10 11 3 3 10 11 0 10 31
12 13 3 3 12 13 0 13 34
14 15 3 3 14 15 0 14 35
16 17 3 3 16 17 0 17 38
18 19 3 3 18 19 0 18 39
1a 1b 3 3 1a 1b 0 1b 3c
1c 1d 3 3 1c 1d 0 1c 3d
1e 1f 3 3 1e 1f 0 1f 05
00 1f 3 2 00 05 0 1f 07
05 05 3 3 25 03 0 05 0a
07 0b 3 3 21 26 0 07 20
0c 0d 1 3 27 28 1 0d 0c
0e 0e 0 1 0e 00 1 0e 0d
01 02 3 3 29 2a 0 02 02
03 04 3 3 2b 2c 0 03 22
00 00 3 0 00 00 0 1e 3f
1f 00 3 1 07 00 0 1f 06
10 1e 3 3 31 3f 0 1e 09
00 00 0 0 00 00 1 10 08
00 00 3 0 00 00 0 05 0a
05 06 3 3 0a 2d 0 06 10
00 00 3 0 00 00 0 05 0f
